//--- fpuMulPkg.sv
`default_nettype none

package fpuMulPkg;

    // Operand and datapath widths
    localparam int DataW = 64;
    localparam int MantW = 53;
    localparam int ProdW = 106;
    localparam int ExpBias = 1023;

    // Radix-4 steps to cover all multiplier bits
    localparam int MulSteps = (MantW + 1) / 2;

    // Register map
    typedef enum logic [1:0] {
        RegOpA  = 2'd0,
        RegOpB  = 2'd1,
        RegCtrl = 2'd2,
        RegStat = 2'd3
    } regAddrE;

    // Significand multiplier sequencer
    typedef enum logic [1:0] {
        Idle = 2'd0,
        Run  = 2'd1,
        Done = 2'd2
    } mulStateE;

    typedef struct packed {
        logic             start;
        logic [MantW-1:0] mantA;
        logic [MantW-1:0] mantB;
    } mulReqT;

    // Shift counts leading zeros below the top product bit
    typedef struct packed {
        logic             ready;
        logic [ProdW-1:0] prod;
        logic [6:0]       shift;
        logic             overflow;
    } mulRspT;

    typedef struct packed {
        logic             valid;
        logic [DataW-1:0] result;
        logic             illegal;
        logic             overflow;
    } fpResT;

    // Software visible status word
    typedef struct packed {
        logic busy;
        logic done;
        logic illegal;
        logic overflow;
    } fpStatT;

endpackage

`default_nettype wire

//--- mantMul53.sv
`timescale 1ns/1ps
`default_nettype none

module mantMul53 (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire fpuMulPkg::mulReqT i_req,
    output fpuMulPkg::mulRspT      o_rsp
);

    fpuMulPkg::mulStateE state;
    logic [4:0] cnt;
    logic [fpuMulPkg::ProdW-1:0] acc;
    logic [fpuMulPkg::ProdW-1:0] mcand;
    logic [fpuMulPkg::MantW:0] mplier;
    logic [fpuMulPkg::ProdW-1:0] partSum;
    logic [6:0] lzCnt;

    // Two partial products from the low multiplier bit pair
    always_comb begin
        partSum = '0;
        if (mplier[0]) begin
            partSum = mcand;
        end
        if (mplier[1]) begin
            partSum = partSum + (mcand << 1);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= fpuMulPkg::Idle;
            cnt <= '0;
        end else begin
            unique case (state)
                fpuMulPkg::Idle: begin
                    if (i_req.start) begin
                        state <= fpuMulPkg::Run;
                        cnt <= '0;
                    end
                end
                fpuMulPkg::Run: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(fpuMulPkg::MulSteps - 1)) begin
                        state <= fpuMulPkg::Done;
                    end
                end
                fpuMulPkg::Done: state <= fpuMulPkg::Idle;
                default: state <= fpuMulPkg::Idle;
            endcase
        end
    end

    // Multiplicand moves up, multiplier moves down two bits per step
    always_ff @(posedge i_clk) begin
        if (state == fpuMulPkg::Idle && i_req.start) begin
            acc <= '0;
            mcand <= {{(fpuMulPkg::ProdW - fpuMulPkg::MantW){1'b0}}, i_req.mantA};
            mplier <= {1'b0, i_req.mantB};
        end else if (state == fpuMulPkg::Run) begin
            acc <= acc + partSum;
            mcand <= mcand << 2;
            mplier <= mplier >> 2;
        end
    end

    // Leading zeros of the lower 105 bits, highest set bit wins
    always_comb begin
        lzCnt = 7'(fpuMulPkg::ProdW - 1);
        for (int i = 0; i < fpuMulPkg::ProdW - 1; i++) begin
            if (acc[i]) begin
                lzCnt = 7'(fpuMulPkg::ProdW - 2 - i);
            end
        end
    end

    always_comb begin
        o_rsp.ready = (state == fpuMulPkg::Done);
        o_rsp.prod = acc;
        o_rsp.shift = lzCnt;
        o_rsp.overflow = acc[fpuMulPkg::ProdW-1];
    end

    ReadyPulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rsp.ready |=> !o_rsp.ready);

endmodule

`default_nettype wire

//--- doubleMul.sv
`timescale 1ns/1ps
`default_nettype none

module doubleMul (
    input  wire logic                        i_clk,
    input  wire logic                        i_nrst,
    input  wire logic                        i_start,
    input  wire logic [fpuMulPkg::DataW-1:0] i_opA,
    input  wire logic [fpuMulPkg::DataW-1:0] i_opB,
    output fpuMulPkg::fpResT                 o_res,
    output logic                             o_busy
);

    logic [fpuMulPkg::DataW-1:0] opA, opB;
    logic busy, valid, accept;
    logic [3:0] ena;
    logic signA, signB, resSign;
    logic [10:0] expA, expB;
    logic zeroA, zeroB, denormA, denormB;
    logic nanA, nanB, infA, infB;
    logic [fpuMulPkg::MantW-1:0] mantA, mantB;
    logic [12:0] expSum, expAB;
    fpuMulPkg::mulReqT mulReq;
    fpuMulPkg::mulRspT mulRsp;
    logic [fpuMulPkg::ProdW-2:0] alignMant, mantAlign, postMant, mantPost;
    logic [12:0] alignExp;
    logic [11:0] alignShift, postShift;
    logic [10:0] expAlign, baseExp, rndExp;
    logic alignOvf, ovfAlign, stickyAlign, postLost, stickyPost;
    logic tieCase, roundUp, carry;
    logic [fpuMulPkg::MantW-1:0] mantShort;
    logic [51:0] rndMant;
    logic [fpuMulPkg::DataW-1:0] resNext, result;
    logic illNext, ovfNext, resIll, resOvf;

    assign accept = i_start && !busy;

    // Operand fields, stable while busy
    assign signA = opA[63];
    assign signB = opB[63];
    assign expA = opA[62:52];
    assign expB = opB[62:52];
    assign zeroA = ~|opA[62:0];
    assign zeroB = ~|opB[62:0];
    assign denormA = ~|expA;
    assign denormB = ~|expB;
    assign nanA = &expA && |opA[51:0];
    assign nanB = &expB && |opB[51:0];
    assign infA = &expA && ~|opA[51:0];
    assign infB = &expB && ~|opB[51:0];
    assign expSum = 13'(expA) + 13'(expB) - 13'(fpuMulPkg::ExpBias);

    assign mulReq = {ena[1], mantA, mantB};

    mantMul53 u_mantMul53 (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .i_req (mulReq),
        .o_rsp (mulRsp)
    );

    // Align by the top product bit, denormal inputs count one exponent higher
    always_comb begin
        if (mulRsp.overflow) begin
            alignMant = mulRsp.prod[fpuMulPkg::ProdW-1:1];
            alignExp = expAB + 13'd1;
        end else begin
            alignMant = mulRsp.prod[fpuMulPkg::ProdW-2:0] << mulRsp.shift;
            alignExp = expAB + 13'(denormA || denormB) - 13'(mulRsp.shift);
        end
        // Exponent field at or below zero needs 1 - exp right shifts
        alignShift = '0;
        if (alignExp[12] || alignExp == '0) begin
            alignShift = ~alignExp[11:0] + 12'd2;
        end
        alignOvf = !alignExp[12] && (alignExp >= 13'd2047);
    end

    always_comb begin
        if (postShift < 12'(fpuMulPkg::ProdW - 1)) begin
            postMant = mantAlign >> postShift;
            postLost = |(mantAlign << (12'(fpuMulPkg::ProdW - 1) - postShift));
        end else begin
            postMant = '0;
            postLost = |mantAlign;
        end
    end

    // Nearest even, sticky bits break exact ties
    always_comb begin
        mantShort = mantPost[fpuMulPkg::ProdW-2 -: fpuMulPkg::MantW];
        tieCase = (mantPost[51:0] == {1'b1, 51'd0}) && !stickyPost;
        roundUp = mantPost[51] && !(tieCase && !mantPost[52]);
        carry = (&mantShort[51:0]) && roundUp;
        rndMant = mantShort[51:0] + 52'(roundUp);
        baseExp = (postShift != '0) ? 11'd0 : expAlign;
        rndExp = baseExp + 11'(carry);
    end

    always_comb begin
        resSign = signA ^ signB;
        illNext = 1'b0;
        ovfNext = 1'b0;
        if (nanA) begin
            resNext = {signA, 11'h7ff, 1'b1, opA[50:0]};
            illNext = 1'b1;
        end else if (nanB) begin
            resNext = {signB, 11'h7ff, 1'b1, opB[50:0]};
            illNext = 1'b1;
        end else if ((infA && zeroB) || (infB && zeroA)) begin
            resNext = {1'b1, 11'h7ff, 1'b1, 51'd0};
            illNext = 1'b1;
        end else if (infA || infB) begin
            resNext = {resSign, 11'h7ff, 52'd0};
        end else if (zeroA || zeroB) begin
            resNext = {resSign, 63'd0};
        end else if (ovfAlign || rndExp == 11'h7ff) begin
            resNext = {resSign, 11'h7ff, 52'd0};
            ovfNext = 1'b1;
        end else begin
            resNext = {resSign, rndExp, rndMant};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy <= 1'b0;
            ena <= '0;
            valid <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (ena[3]) begin
                busy <= 1'b0;
            end
            ena <= {ena[2], mulRsp.ready, ena[0], accept};
            valid <= ena[3];
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            opA <= i_opA;
            opB <= i_opB;
        end
        if (ena[0]) begin
            mantA <= {~denormA, opA[51:0]};
            mantB <= {~denormB, opB[51:0]};
            expAB <= expSum;
        end
        if (mulRsp.ready) begin
            mantAlign <= alignMant;
            expAlign <= alignExp[10:0];
            postShift <= alignShift;
            ovfAlign <= alignOvf;
            stickyAlign <= mulRsp.overflow && mulRsp.prod[0];
        end
        if (ena[2]) begin
            mantPost <= postMant;
            stickyPost <= stickyAlign || postLost;
        end
        if (ena[3]) begin
            result <= resNext;
            resIll <= illNext;
            resOvf <= ovfNext;
        end
    end

    assign o_res = {valid, result, resIll, resOvf};
    assign o_busy = busy;

    // Valid marks the cycle busy has just dropped
    ValidEndsBusy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        valid |-> $past(busy) && !busy);

    NoRelatch: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_start && busy) |=> $stable(opA) && $stable(opB));

endmodule

`default_nettype wire

//--- fpuMulRegs.sv
`timescale 1ns/1ps
`default_nettype none

module fpuMulRegs (
    input  wire logic                        i_clk,
    input  wire logic                        i_nrst,
    input  wire logic                        i_wrEn,
    input  wire fpuMulPkg::regAddrE          i_wrAddr,
    input  wire logic [fpuMulPkg::DataW-1:0] i_wrData,
    input  wire fpuMulPkg::regAddrE          i_rdAddr,
    input  wire fpuMulPkg::fpResT            i_res,
    input  wire logic                        i_busy,
    output logic                             o_start,
    output logic [fpuMulPkg::DataW-1:0]      o_opA,
    output logic [fpuMulPkg::DataW-1:0]      o_opB,
    output logic [fpuMulPkg::DataW-1:0]      o_rdData,
    output fpuMulPkg::fpStatT                o_status
);

    logic ctrlWr, statWr;
    logic [fpuMulPkg::DataW-1:0] result;
    logic done, stickyIll, stickyOvf;

    assign ctrlWr = i_wrEn && (i_wrAddr == fpuMulPkg::RegCtrl) && i_wrData[0];
    assign statWr = i_wrEn && (i_wrAddr == fpuMulPkg::RegStat);

    always_ff @(posedge i_clk) begin
        if (i_wrEn && i_wrAddr == fpuMulPkg::RegOpA) begin
            o_opA <= i_wrData;
        end
        if (i_wrEn && i_wrAddr == fpuMulPkg::RegOpB) begin
            o_opB <= i_wrData;
        end
        if (i_res.valid) begin
            result <= i_res.result;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_start <= 1'b0;
            done <= 1'b0;
            stickyIll <= 1'b0;
            stickyOvf <= 1'b0;
        end else begin
            o_start <= ctrlWr && !o_start;
            // A new start clears done
            if (i_res.valid) begin
                done <= 1'b1;
            end else if (o_start) begin
                done <= 1'b0;
            end
            stickyIll <= (stickyIll && !statWr) || (i_res.valid && i_res.illegal);
            stickyOvf <= (stickyOvf && !statWr) || (i_res.valid && i_res.overflow);
        end
    end

    always_comb begin
        unique case (i_rdAddr)
            fpuMulPkg::RegOpA: o_rdData = o_opA;
            fpuMulPkg::RegOpB: o_rdData = o_opB;
            fpuMulPkg::RegCtrl: o_rdData = '0;
            default: o_rdData = result;
        endcase
        o_status = {i_busy, done, stickyIll, stickyOvf};
    end

    StartPulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_start |=> !o_start);

endmodule

`default_nettype wire

//--- fpuMulTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpuMulTop (
    input  wire logic                        i_clk,
    input  wire logic                        i_nrst,
    input  wire logic                        i_wrEn,
    input  wire fpuMulPkg::regAddrE          i_wrAddr,
    input  wire logic [fpuMulPkg::DataW-1:0] i_wrData,
    input  wire fpuMulPkg::regAddrE          i_rdAddr,
    output logic [fpuMulPkg::DataW-1:0]      o_rdData,
    output fpuMulPkg::fpStatT                o_status
);

    logic start, busy;
    logic [fpuMulPkg::DataW-1:0] opA, opB;
    fpuMulPkg::fpResT res;

    // Register block
    fpuMulRegs u_regs (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_wrEn  (i_wrEn),
        .i_wrAddr(i_wrAddr),
        .i_wrData(i_wrData),
        .i_rdAddr(i_rdAddr),
        .i_res   (res),
        .i_busy  (busy),
        .o_start (start),
        .o_opA   (opA),
        .o_opB   (opB),
        .o_rdData(o_rdData),
        .o_status(o_status)
    );

    doubleMul u_doubleMul (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_start(start),
        .i_opA  (opA),
        .i_opB  (opB),
        .o_res  (res),
        .o_busy (busy)
    );

endmodule

`default_nettype wire

//--- fpuMulTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpuMulTb;

    localparam int MaxVec = 32;
    localparam int StartLimit = 10;
    localparam int DoneLimit = 200;
    localparam int HoldCycles = 60;

    logic clk;
    logic nrst;
    logic wrEn;
    fpuMulPkg::regAddrE wrAddr;
    logic [fpuMulPkg::DataW-1:0] wrData;
    fpuMulPkg::regAddrE rdAddr;
    logic [fpuMulPkg::DataW-1:0] rdData;
    fpuMulPkg::fpStatT status;

    // Vector table from the stimulus file
    logic [8*24-1:0] vecName [MaxVec];
    logic [fpuMulPkg::DataW-1:0] vecOpA [MaxVec];
    logic [fpuMulPkg::DataW-1:0] vecOpB [MaxVec];
    logic [fpuMulPkg::DataW-1:0] vecRes [MaxVec];
    logic vecIll [MaxVec];
    logic vecOvf [MaxVec];
    int numVec;

    fpuMulTop uut (
        .i_clk   (clk),
        .i_nrst  (nrst),
        .i_wrEn  (wrEn),
        .i_wrAddr(wrAddr),
        .i_wrData(wrData),
        .i_rdAddr(rdAddr),
        .o_rdData(rdData),
        .o_status(status)
    );

    always #4 clk = ~clk;

    task automatic compareValue(input logic [8*24-1:0] testName, input logic [8*8-1:0] what,
                                input logic [63:0] expVal, input logic [63:0] actVal);
        if (expVal !== actVal) begin
            $display("error %0s %0s expected %h actual %h", testName, what, expVal, actVal);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // All register tasks start and end on a falling edge
    task automatic writeReg(input fpuMulPkg::regAddrE addr, input logic [63:0] data);
        wrEn = 1'b1;
        wrAddr = addr;
        wrData = data;
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic readReg(input fpuMulPkg::regAddrE addr, output logic [63:0] data);
        rdAddr = addr;
        @(negedge clk);
        data = rdData;
    endtask

    task automatic waitFlag(input logic [8*24-1:0] testName, input logic useBusy,
                            input logic level, input int limit);
        int cycles;
        logic flag;
        cycles = 0;
        flag = useBusy ? status.busy : status.done;
        while (flag !== level) begin
            if (cycles >= limit) begin
                $display("timeout in %0s, status flag never went to %0b", testName, level);
                $display("sim failed");
                $fatal(1);
            end
            @(negedge clk);
            cycles++;
            flag = useBusy ? status.busy : status.done;
        end
    endtask

    task automatic runVector(input int idx);
        logic [63:0] readVal;
        writeReg(fpuMulPkg::RegOpA, vecOpA[idx]);
        writeReg(fpuMulPkg::RegOpB, vecOpB[idx]);
        readReg(fpuMulPkg::RegOpA, readVal);
        compareValue(vecName[idx], "opA", vecOpA[idx], readVal);
        readReg(fpuMulPkg::RegOpB, readVal);
        compareValue(vecName[idx], "opB", vecOpB[idx], readVal);
        writeReg(fpuMulPkg::RegCtrl, 64'd1);
        // Done from the last vector drops once the start is taken
        waitFlag(vecName[idx], 1'b0, 1'b0, StartLimit);
        waitFlag(vecName[idx], 1'b0, 1'b1, DoneLimit);
        readReg(fpuMulPkg::RegStat, readVal);
        compareValue(vecName[idx], "result", vecRes[idx], readVal);
        compareValue(vecName[idx], "illegal", 64'(vecIll[idx]), 64'(status.illegal));
        compareValue(vecName[idx], "overflow", 64'(vecOvf[idx]), 64'(status.overflow));
        writeReg(fpuMulPkg::RegStat, 64'd0);
        compareValue(vecName[idx], "clrIll", 64'd0, 64'(status.illegal));
        compareValue(vecName[idx], "clrOvf", 64'd0, 64'(status.overflow));
    endtask

    // Second start during a run must not touch the result
    task automatic busyIgnore();
        logic [8*24-1:0] testName;
        logic [63:0] readVal;
        testName = "busy_ignore";
        writeReg(fpuMulPkg::RegOpA, vecOpA[0]);
        writeReg(fpuMulPkg::RegOpB, vecOpB[0]);
        writeReg(fpuMulPkg::RegCtrl, 64'd1);
        waitFlag(testName, 1'b1, 1'b1, StartLimit);
        writeReg(fpuMulPkg::RegOpA, vecOpA[1]);
        writeReg(fpuMulPkg::RegOpB, vecOpB[1]);
        compareValue(testName, "busy", 64'd1, 64'(status.busy));
        writeReg(fpuMulPkg::RegCtrl, 64'd1);
        compareValue(testName, "done", 64'd0, 64'(status.done));
        waitFlag(testName, 1'b0, 1'b1, DoneLimit);
        readReg(fpuMulPkg::RegStat, readVal);
        compareValue(testName, "result", vecRes[0], readVal);
        for (int i = 0; i < HoldCycles; i++) begin
            @(negedge clk);
            compareValue(testName, "busy", 64'd0, 64'(status.busy));
            compareValue(testName, "done", 64'd1, 64'(status.done));
        end
        // A fresh start picks up the operands of the second vector
        writeReg(fpuMulPkg::RegCtrl, 64'd1);
        waitFlag(testName, 1'b0, 1'b0, StartLimit);
        waitFlag(testName, 1'b0, 1'b1, DoneLimit);
        readReg(fpuMulPkg::RegStat, readVal);
        compareValue(testName, "result", vecRes[1], readVal);
        writeReg(fpuMulPkg::RegStat, 64'd0);
    endtask

    initial begin
        int fd;
        int code;
        logic [8*24-1:0] name;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic ill;
        logic ovf;
        clk = 1'b0;
        nrst = 1'b0;
        wrEn = 1'b0;
        wrAddr = fpuMulPkg::RegOpA;
        wrData = '0;
        rdAddr = fpuMulPkg::RegOpA;
        numVec = 0;
        fd = $fopen("fpuMulStim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file fpuMulStim.txt");
            $display("sim failed");
            $fatal(1);
        end
        code = $fscanf(fd, "%s %h %h %h %b %b", name, a, b, r, ill, ovf);
        while (code == 6 && numVec < MaxVec) begin
            vecName[numVec] = name;
            vecOpA[numVec] = a;
            vecOpB[numVec] = b;
            vecRes[numVec] = r;
            vecIll[numVec] = ill;
            vecOvf[numVec] = ovf;
            numVec++;
            code = $fscanf(fd, "%s %h %h %h %b %b", name, a, b, r, ill, ovf);
        end
        $fclose(fd);
        if (numVec < 2) begin
            $display("the stimulus file holds fewer than two usable vectors");
            $display("sim failed");
            $fatal(1);
        end
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        compareValue("reset", "status", 64'd0, 64'(status));
        for (int i = 0; i < numVec; i++) begin
            runVector(i);
        end
        busyIgnore();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpuMul.f
fpuMulPkg.sv
mantMul53.sv
doubleMul.sv
fpuMulRegs.sv
fpuMulTop.sv
fpuMulTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fpuMulTb
FILELIST  ?= fpuMul.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fpuMulStim.txt
one_x_one 3ff0000000000000 3ff0000000000000 3ff0000000000000 0 0
neg_mixed bff8000000000000 4004000000000000 c00e000000000000 0 0
ulp_square 3ff0000000000001 3ff0000000000001 3ff0000000000002 0 0
tie_odd_up 3ff0000000000001 3ff8000000000000 3ff8000000000002 0 0
tie_even_stay 3ff0000000000003 3ff8000000000000 3ff8000000000004 0 0
carry_exp 3ffffffffc000000 3ff0000002000000 4000000000000000 0 0
max_mant_sq 3fffffffffffffff 3fffffffffffffff 400ffffffffffffe 0 0
pos_zero 0000000000000000 c014000000000000 8000000000000000 0 0
neg_zero_sq 8000000000000000 8000000000000000 0000000000000000 0 0
to_denorm 0010000000000000 3fe0000000000000 0008000000000000 0 0
denorm_norm 0000000000000001 7fe0000000000000 3cc0000000000000 0 0
denorm_tie 0000000000000003 3fe0000000000000 0000000000000002 0 0
flush_tie 0000000000000001 3fe0000000000000 0000000000000000 0 0
ovf_pos 7fe0000000000000 4000000000000000 7ff0000000000000 0 1
ovf_neg ffe0000000000000 4000000000000000 fff0000000000000 0 1
ovf_round 7feffffffc000000 3ff0000002000000 7ff0000000000000 0 1
inf_sq fff0000000000000 c008000000000000 7ff0000000000000 0 0
qnan_a 7ff8000000000123 3ff0000000000000 7ff8000000000123 1 0
snan_b 3ff0000000000000 fff4000000000000 fffc000000000000 1 0
inf_x_zero 7ff0000000000000 0000000000000000 fff8000000000000 1 0
